//--- sim.f
+incdir+include
verilog/sdmac_pkg.sv
verilog/sdmac_addr_decoder.sv
verilog/sdmac_ctrl_regs.sv
verilog/sdmac_dma_state.sv
verilog/sdmac_read_mux.sv
verilog/sdmac_regs_top.sv
verification/tb_clk_gen.sv
verification/tb_sdmac_regs.sv

//--- Makefile
# Verilator simulation of the SDMAC register interface

VERILATOR ?= verilator
TOP       ?= tb_sdmac_regs
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_sdmac_regs.sv
// SDMAC register interface testbench
`default_nettype none
`include "sdmac_cfg.svh"

module tb_sdmac_regs;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS       = 4;
  localparam int RESET_CYCLES = 8;
  localparam int N_DECODE     = 500;
  localparam int N_RW         = 60;
  localparam int N_DMA        = 80;
  // Every test cycle plus the fixed sequences of the directed tests
  localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + 5 + N_DECODE + 2 * N_RW + N_DMA + 8 + 20 + 8;
  localparam int TIMEOUT_NS   = TOTAL_CYCLES * CLK_NS + 200;

  logic                 clk;
  logic                 rst_n;
  logic [7:0]           addr;
  logic                 dmac_n, as_n, rw;
  logic [`SDMAC_DW-1:0] data_in;
  logic                 scsi_int, dma_ack;
  logic [`SDMAC_DW-1:0] data_out;
  logic                 data_oe, wdregreq, int_n, dma_dir;

  // Reference model state
  logic [7:0]  m_contr;
  logic [31:0] m_acr, m_sspbdat, m_wtc;
  logic        m_running, m_int_p, m_flushed;

  logic [31:0] seed;
  logic [31:0] last_data;
  logic        last_oe, last_int_n, last_dma_dir;
  string       cur_test;
  int          test_errs;
  int          pass_count;
  int          fail_count;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (.clk(clk));

  sdmac_regs_top sdmac_regs_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr     (addr),
    .dmac_n   (dmac_n),
    .as_n     (as_n),
    .rw       (rw),
    .data_in  (data_in),
    .scsi_int (scsi_int),
    .dma_ack  (dma_ack),
    .data_out (data_out),
    .data_oe  (data_oe),
    .wdregreq (wdregreq),
    .int_n    (int_n),
    .dma_dir  (dma_dir)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [7:0] reg_offset(input int idx);
    case (idx)
      0: return sdmac_pkg::WTC;
      1: return sdmac_pkg::CONTR;
      2: return sdmac_pkg::ACR;
      3: return sdmac_pkg::ST_DMA;
      4: return sdmac_pkg::FLUSH;
      5: return sdmac_pkg::CLR_INT;
      6: return sdmac_pkg::ISTR;
      7: return sdmac_pkg::VERSION;
      8: return sdmac_pkg::SP_DMA;
      default: return sdmac_pkg::SSPBDAT;
    endcase
  endfunction

  function automatic logic [31:0] model_istr(input logic si);
    logic [31:0] w;
    w = '0;
    w[sdmac_pkg::ISTR_INT_P]   = m_int_p;
    w[sdmac_pkg::ISTR_RUN]     = m_running;
    w[sdmac_pkg::ISTR_SCSI]    = si; // Raw line that is not latched
    w[sdmac_pkg::ISTR_FLUSHED] = m_flushed;
    return w;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s/%s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
      pass_count++;
    end else begin
      $display("test %s: %0d mismatches", cur_test, test_errs);
      fail_count++;
    end
  endtask

  // Clock edge effects of one bus cycle
  task automatic update_model(input logic [7:0] a, input logic valid, input logic r,
                              input logic [31:0] d, input logic si, input logic ack);
    logic wr;
    logic xfer;
    wr   = valid && !r;
    xfer = ack && m_running;
    if (wr && a == sdmac_pkg::CONTR) m_contr = d[7:0];
    if (wr && a == sdmac_pkg::SSPBDAT) m_sspbdat = d;
    if (wr && a == sdmac_pkg::ACR) m_acr = d;
    else if (xfer) m_acr = m_acr + `SDMAC_ACR_STEP;
    if (valid && a == sdmac_pkg::ST_DMA) begin
      m_running = 1'b1;
      m_wtc     = '0;
      m_flushed = 1'b0;
    end else begin
      if (valid && a == sdmac_pkg::SP_DMA) m_running = 1'b0;
      if (xfer) m_wtc = m_wtc + 32'd1;
      if (valid && a == sdmac_pkg::FLUSH) m_flushed = 1'b1;
    end
    if (si) m_int_p = 1'b1; // Set wins over clear
    else if (valid && a == sdmac_pkg::CLR_INT) m_int_p = 1'b0;
  endtask

  // One clock of bus activity checked against the model
  task automatic bus_cycle(input logic [7:0] a, input logic cs_n, input logic strb_n,
                           input logic r, input logic [31:0] d, input logic si,
                           input logic ack);
    logic        valid;
    logic        exp_oe;
    logic [31:0] exp_data;
    @(negedge clk);
    addr     = a;
    dmac_n   = cs_n;
    as_n     = strb_n;
    rw       = r;
    data_in  = d;
    scsi_int = si;
    dma_ack  = ack;
    #1;
    valid    = !cs_n && !strb_n;
    exp_oe   = valid && r;
    exp_data = '0;
    if (exp_oe) begin
      case (a)
        sdmac_pkg::WTC:     exp_data = m_wtc;
        sdmac_pkg::CONTR:   exp_data = {24'h0, m_contr};
        sdmac_pkg::ACR:     exp_data = m_acr;
        sdmac_pkg::ISTR:    exp_data = model_istr(si);
        sdmac_pkg::VERSION: exp_data = `SDMAC_VERSION;
        sdmac_pkg::SSPBDAT: exp_data = m_sspbdat;
        default:            exp_oe = 1'b0;
      endcase
    end
    check_value("data_oe", 32'(exp_oe), 32'(data_oe));
    check_value("data_out", exp_data, data_out);
    check_value("wdregreq", 32'(valid && a[7:4] == 4'h4), 32'(wdregreq));
    check_value("int_n", 32'(!(m_int_p && m_contr[sdmac_pkg::CONTR_IE])), 32'(int_n));
    check_value("dma_dir", 32'(m_contr[sdmac_pkg::CONTR_DIR]), 32'(dma_dir));
    last_data    = data_out;
    last_oe      = data_oe;
    last_int_n   = int_n;
    last_dma_dir = dma_dir;
    @(posedge clk);
    update_model(a, valid, r, d, si, ack);
  endtask

  task automatic read_reg(input logic [7:0] a, output logic [31:0] val);
    bus_cycle(a, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
    val = last_data;
  endtask

  task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
    bus_cycle(a, 1'b0, 1'b0, 1'b0, d, 1'b0, 1'b0);
  endtask

  task automatic do_action(input logic [7:0] a);
    bus_cycle(a, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic idle_cycle(input logic ack, input logic si);
    bus_cycle(8'h00, 1'b1, 1'b1, 1'b1, 32'h0, si, ack);
  endtask

  task automatic reset_values();
    logic [31:0] val;
    begin_test("reset");
    idle_cycle(1'b0, 1'b0);
    check_value("idle_oe", 32'h0, 32'(last_oe));
    check_value("idle_int_n", 32'h1, 32'(last_int_n));
    read_reg(sdmac_pkg::CONTR, val);
    check_value("contr", 32'h0, val);
    read_reg(sdmac_pkg::ACR, val);
    check_value("acr", 32'h0, val);
    read_reg(sdmac_pkg::WTC, val);
    check_value("wtc", 32'h0, val);
    read_reg(sdmac_pkg::ISTR, val);
    check_value("istr", 32'h0, val);
    end_test();
  endtask

  task automatic random_decode();
    logic [31:0] r;
    logic [7:0]  a;
    begin_test("decode");
    for (int i = 0; i < N_DECODE; i++) begin
      r = next_rand();
      case (r[7:6])
        2'd0, 2'd1: a = reg_offset(int'(r[15:8]) % 10);
        2'd2:       a = {4'h4, r[11:8]}; // WD33C93 window
        default:    a = r[23:16];
      endcase
      bus_cycle(a, r[25:24] == 2'b00, r[27:26] == 2'b00, r[28], next_rand(),
                r[31:29] == 3'b000, r[5]);
    end
    end_test();
  endtask

  task automatic write_readback();
    logic [31:0] r, d, val, exp;
    logic [7:0]  a;
    begin_test("write_read");
    for (int i = 0; i < N_RW; i++) begin
      r = next_rand();
      d = next_rand();
      case (r % 32'd3)
        32'd0:   a = sdmac_pkg::CONTR;
        32'd1:   a = sdmac_pkg::ACR;
        default: a = sdmac_pkg::SSPBDAT;
      endcase
      write_reg(a, d);
      read_reg(a, val);
      exp = (a == sdmac_pkg::CONTR) ? {24'h0, d[7:0]} : d; // CONTR is one byte
      check_value("readback", exp, val);
      if (a == sdmac_pkg::CONTR)
        check_value("dir_bit", 32'(d[sdmac_pkg::CONTR_DIR]), 32'(last_dma_dir));
    end
    end_test();
  endtask

  task automatic dma_counting();
    logic [31:0] base, acks, r, val;
    begin_test("dma_count");
    base = next_rand();
    acks = '0;
    write_reg(sdmac_pkg::ACR, base);
    do_action(sdmac_pkg::ST_DMA);
    for (int i = 0; i < N_DMA; i++) begin
      r = next_rand();
      idle_cycle(r[7], 1'b0);
      if (r[7]) acks = acks + 32'd1;
    end
    do_action(sdmac_pkg::SP_DMA);
    idle_cycle(1'b1, 1'b0); // Ignored once stopped
    idle_cycle(1'b1, 1'b0);
    read_reg(sdmac_pkg::WTC, val);
    check_value("wtc", acks, val);
    read_reg(sdmac_pkg::ACR, val);
    check_value("acr", base + acks * `SDMAC_ACR_STEP, val);
    end_test();
  endtask

  task automatic interrupt_flow();
    logic [31:0] val;
    begin_test("interrupt");
    write_reg(sdmac_pkg::CONTR, 32'h1 << sdmac_pkg::CONTR_IE);
    do_action(sdmac_pkg::CLR_INT);
    idle_cycle(1'b0, 1'b0);
    check_value("int_n_idle", 32'h1, 32'(last_int_n));
    idle_cycle(1'b0, 1'b1);
    idle_cycle(1'b0, 1'b0);
    check_value("int_n_set", 32'h0, 32'(last_int_n));
    bus_cycle(sdmac_pkg::CLR_INT, 1'b0, 1'b0, 1'b1, 32'h0, 1'b1, 1'b0); // Still requesting
    idle_cycle(1'b0, 1'b0);
    check_value("int_n_held", 32'h0, 32'(last_int_n));
    do_action(sdmac_pkg::CLR_INT);
    idle_cycle(1'b0, 1'b0);
    check_value("int_n_clr", 32'h1, 32'(last_int_n));
    write_reg(sdmac_pkg::CONTR, 32'h0);
    idle_cycle(1'b0, 1'b1);
    idle_cycle(1'b0, 1'b0);
    check_value("int_n_masked", 32'h1, 32'(last_int_n));
    read_reg(sdmac_pkg::ISTR, val);
    check_value("pending_bit", 32'h1, 32'(val[sdmac_pkg::ISTR_INT_P]));
    do_action(sdmac_pkg::CLR_INT);
    end_test();
  endtask

  task automatic flush_flag();
    logic [31:0] val;
    begin_test("flush");
    do_action(sdmac_pkg::FLUSH);
    read_reg(sdmac_pkg::ISTR, val);
    check_value("flushed_set", 32'h1, 32'(val[sdmac_pkg::ISTR_FLUSHED]));
    do_action(sdmac_pkg::ST_DMA);
    read_reg(sdmac_pkg::ISTR, val);
    check_value("flushed_clr", 32'h0, 32'(val[sdmac_pkg::ISTR_FLUSHED]));
    check_value("running", 32'h1, 32'(val[sdmac_pkg::ISTR_RUN]));
    do_action(sdmac_pkg::SP_DMA);
    end_test();
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    addr       = 8'h00;
    dmac_n     = 1'b1;
    as_n       = 1'b1;
    rw         = 1'b1;
    data_in    = '0;
    scsi_int   = 1'b0;
    dma_ack    = 1'b0;
    seed       = 32'h4e088306;
    pass_count = 0;
    fail_count = 0;
    m_contr    = '0;
    m_acr      = '0;
    m_sspbdat  = '0;
    m_wtc      = '0;
    m_running  = 1'b0;
    m_int_p    = 1'b0;
    m_flushed  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    random_decode();
    write_readback();
    dma_counting();
    interrupt_flow();
    flush_flag();
    $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// Testbench clock source
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk; // Half period per toggle

endmodule

`default_nettype wire

//--- verilog/sdmac_regs_top.sv
// SDMAC register interface top level
`default_nettype none
`include "sdmac_cfg.svh"

module sdmac_regs_top (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire [7:0]            addr,
  input  wire                  dmac_n,
  input  wire                  as_n,
  input  wire                  rw,
  input  wire [`SDMAC_DW-1:0]  data_in,
  input  wire                  scsi_int,
  input  wire                  dma_ack,
  output logic [`SDMAC_DW-1:0] data_out,
  output logic                 data_oe,
  output logic                 wdregreq, // WD33C93 register access
  output logic                 int_n,
  output logic                 dma_dir    // To the data path
);

  // Decoder strobes
  logic wtc_rd_n, contr_rd_n, istr_rd_n, version_rd_n, sspbdat_rd_n, acr_rd_n;
  logic contr_wr, acr_wr, sspbdat_wr;
  logic st_dma, sp_dma, clr_int, flush_n;

  // Register state
  logic [7:0]           contr;
  logic [`SDMAC_DW-1:0] acr;
  logic [`SDMAC_DW-1:0] sspbdat;
  logic [`SDMAC_DW-1:0] wtc;
  logic                 int_enable;
  logic                 running, int_pending, flushed, xfer;

  sdmac_addr_decoder u_decoder (
    .addr         (addr),
    .dmac_n       (dmac_n),
    .as_n         (as_n),
    .rw           (rw),
    .wd_sel       (wdregreq),
    .wtc_rd_n     (wtc_rd_n),
    .contr_rd_n   (contr_rd_n),
    .istr_rd_n    (istr_rd_n),
    .version_rd_n (version_rd_n),
    .sspbdat_rd_n (sspbdat_rd_n),
    .acr_rd_n     (acr_rd_n),
    .contr_wr     (contr_wr),
    .acr_wr       (acr_wr),
    .sspbdat_wr   (sspbdat_wr),
    .st_dma       (st_dma),
    .sp_dma       (sp_dma),
    .clr_int      (clr_int),
    .flush_n      (flush_n)
  );

  sdmac_ctrl_regs u_ctrl_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_in    (data_in),
    .contr_wr   (contr_wr),
    .acr_wr     (acr_wr),
    .sspbdat_wr (sspbdat_wr),
    .xfer       (xfer),
    .contr      (contr),
    .acr        (acr),
    .sspbdat    (sspbdat),
    .int_enable (int_enable),
    .dma_dir    (dma_dir)
  );

  sdmac_dma_state u_dma_state (
    .clk         (clk),
    .rst_n       (rst_n),
    .st_dma      (st_dma),
    .sp_dma      (sp_dma),
    .clr_int     (clr_int),
    .flush_n     (flush_n),
    .scsi_int    (scsi_int),
    .dma_ack     (dma_ack),
    .int_enable  (int_enable),
    .running     (running),
    .int_pending (int_pending),
    .flushed     (flushed),
    .wtc         (wtc),
    .xfer        (xfer),
    .int_n       (int_n)
  );

  sdmac_read_mux u_read_mux (
    .wtc_rd_n     (wtc_rd_n),
    .contr_rd_n   (contr_rd_n),
    .istr_rd_n    (istr_rd_n),
    .version_rd_n (version_rd_n),
    .sspbdat_rd_n (sspbdat_rd_n),
    .acr_rd_n     (acr_rd_n),
    .contr        (contr),
    .acr          (acr),
    .sspbdat      (sspbdat),
    .wtc          (wtc),
    .running      (running),
    .int_pending  (int_pending),
    .flushed      (flushed),
    .scsi_int     (scsi_int),
    .data_out     (data_out),
    .data_oe      (data_oe)
  );

endmodule

`default_nettype wire

//--- verilog/sdmac_read_mux.sv
// SDMAC CPU read data multiplexer
`default_nettype none
`include "sdmac_cfg.svh"

module sdmac_read_mux (
  input  wire                  wtc_rd_n,
  input  wire                  contr_rd_n,
  input  wire                  istr_rd_n,
  input  wire                  version_rd_n,
  input  wire                  sspbdat_rd_n,
  input  wire                  acr_rd_n,
  input  wire [7:0]            contr,
  input  wire [`SDMAC_DW-1:0]  acr,
  input  wire [`SDMAC_DW-1:0]  sspbdat,
  input  wire [`SDMAC_DW-1:0]  wtc,
  input  wire                  running,
  input  wire                  int_pending,
  input  wire                  flushed,
  input  wire                  scsi_int,
  output logic [`SDMAC_DW-1:0] data_out,
  output logic                 data_oe
);

  logic [`SDMAC_DW-1:0] istr;

  // Status word
  always_comb begin
    istr                           = '0;
    istr[sdmac_pkg::ISTR_INT_P]   = int_pending;
    istr[sdmac_pkg::ISTR_RUN]     = running;
    istr[sdmac_pkg::ISTR_SCSI]    = scsi_int; // Unlatched
    istr[sdmac_pkg::ISTR_FLUSHED] = flushed;
  end

  // Strobes are one-hot from the decoder
  always_comb begin
    data_out = '0;
    if (!wtc_rd_n) begin
      data_out = wtc;
    end else if (!contr_rd_n) begin
      data_out = {{(`SDMAC_DW-8){1'b0}}, contr};
    end else if (!istr_rd_n) begin
      data_out = istr;
    end else if (!version_rd_n) begin
      data_out = `SDMAC_VERSION;
    end else if (!sspbdat_rd_n) begin
      data_out = sspbdat;
    end else if (!acr_rd_n) begin
      data_out = acr;
    end
  end

  assign data_oe = ~&{wtc_rd_n, contr_rd_n, istr_rd_n,
                      version_rd_n, sspbdat_rd_n, acr_rd_n};

endmodule

`default_nettype wire

//--- verilog/sdmac_dma_state.sv
// SDMAC DMA state and interrupt
`default_nettype none
`include "sdmac_cfg.svh"

module sdmac_dma_state (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  st_dma,
  input  wire                  sp_dma,
  input  wire                  clr_int,
  input  wire                  flush_n,
  input  wire                  scsi_int,   // Raw request from the WD33C93
  input  wire                  dma_ack,
  input  wire                  int_enable,
  output logic                 running,
  output logic                 int_pending,
  output logic                 flushed,
  output logic [`SDMAC_DW-1:0] wtc,
  output logic                 xfer,
  output logic                 int_n
);

  // A transfer only counts while DMA is running
  assign xfer = dma_ack & running;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else if (st_dma) begin
      running <= 1'b1;
    end else if (sp_dma) begin
      running <= 1'b0;
    end
  end

  // Word transfer count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wtc <= '0;
    end else if (st_dma) begin
      wtc <= '0;
    end else if (xfer) begin
      wtc <= wtc + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      int_pending <= 1'b0;
    end else if (scsi_int) begin
      int_pending <= 1'b1; // New request wins over a clear
    end else if (clr_int) begin
      int_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flushed <= 1'b0;
    end else if (st_dma) begin
      flushed <= 1'b0;
    end else if (!flush_n) begin
      flushed <= 1'b1;
    end
  end

  // Active-low interrupt line to the host
  assign int_n = ~(int_pending & int_enable);

endmodule

`default_nettype wire

//--- verilog/sdmac_ctrl_regs.sv
// SDMAC control registers
`default_nettype none
`include "sdmac_cfg.svh"

module sdmac_ctrl_regs (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire [`SDMAC_DW-1:0] data_in,
  input  wire                 contr_wr,
  input  wire                 acr_wr,
  input  wire                 sspbdat_wr,
  input  wire                 xfer,       // One DMA transfer this cycle
  output logic [7:0]          contr,
  output logic [`SDMAC_DW-1:0] acr,
  output logic [`SDMAC_DW-1:0] sspbdat,
  output logic                int_enable,
  output logic                dma_dir
);

  localparam logic [`SDMAC_DW-1:0] ACR_STEP = `SDMAC_ACR_STEP;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      contr <= '0;
    end else if (contr_wr) begin
      contr <= data_in[7:0]; // Only the low byte exists
    end
  end

  // Address counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acr <= '0;
    end else if (acr_wr) begin
      acr <= data_in; // CPU write beats the increment
    end else if (xfer) begin
      acr <= acr + ACR_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sspbdat <= '0;
    end else if (sspbdat_wr) begin
      sspbdat <= data_in;
    end
  end

  assign int_enable = contr[sdmac_pkg::CONTR_IE];
  assign dma_dir    = contr[sdmac_pkg::CONTR_DIR];

endmodule

`default_nettype wire

//--- verilog/sdmac_addr_decoder.sv
// SDMAC bus cycle address decoder
`default_nettype none

module sdmac_addr_decoder (
  input  wire [7:0] addr,   // Register offset from the CPU
  input  wire       dmac_n, // Chip select
  input  wire       as_n,   // Address strobe
  input  wire       rw,     // High for read
  output logic      wd_sel,
  output logic      wtc_rd_n,
  output logic      contr_rd_n,
  output logic      istr_rd_n,
  output logic      version_rd_n,
  output logic      sspbdat_rd_n,
  output logic      acr_rd_n,
  output logic      contr_wr,
  output logic      acr_wr,
  output logic      sspbdat_wr,
  output logic      st_dma,
  output logic      sp_dma,
  output logic      clr_int,
  output logic      flush_n
);

  logic valid;
  logic hit_wtc, hit_contr, hit_acr, hit_istr, hit_version, hit_sspbdat;

  assign valid = ~(dmac_n | as_n);

  // Register matches
  assign hit_wtc     = valid & (addr == sdmac_pkg::WTC);
  assign hit_contr   = valid & (addr == sdmac_pkg::CONTR);
  assign hit_acr     = valid & (addr == sdmac_pkg::ACR);
  assign hit_istr    = valid & (addr == sdmac_pkg::ISTR);
  assign hit_version = valid & (addr == sdmac_pkg::VERSION);
  assign hit_sspbdat = valid & (addr == sdmac_pkg::SSPBDAT);

  assign wd_sel = valid & (addr[7:4] == 4'h4); // WD33C93 window

  assign wtc_rd_n     = ~(hit_wtc & rw);
  assign contr_rd_n   = ~(hit_contr & rw);
  assign istr_rd_n    = ~(hit_istr & rw);
  assign version_rd_n = ~(hit_version & rw);
  assign sspbdat_rd_n = ~(hit_sspbdat & rw);
  assign acr_rd_n     = ~(hit_acr & rw);

  assign contr_wr   = hit_contr & ~rw;
  assign acr_wr     = hit_acr & ~rw;
  assign sspbdat_wr = hit_sspbdat & ~rw;

  // Action offsets fire on any access
  assign st_dma  = valid & (addr == sdmac_pkg::ST_DMA);
  assign sp_dma  = valid & (addr == sdmac_pkg::SP_DMA);
  assign clr_int = valid & (addr == sdmac_pkg::CLR_INT);
  assign flush_n = ~(valid & (addr == sdmac_pkg::FLUSH));

endmodule

`default_nettype wire

//--- verilog/sdmac_pkg.sv
// SDMAC register map definitions
`default_nettype none

package sdmac_pkg;

  // Register offsets on the CPU bus
  typedef enum logic [7:0] {
    WTC     = 8'h04,
    CONTR   = 8'h08,
    ACR     = 8'h0C,
    ST_DMA  = 8'h10,
    FLUSH   = 8'h14,
    CLR_INT = 8'h18,
    ISTR    = 8'h1C,
    VERSION = 8'h20,
    SP_DMA  = 8'h3C,
    SSPBDAT = 8'h58
  } reg_off_e;

  // CONTR bits
  localparam int CONTR_DIR = 1; // 1 = memory to SCSI
  localparam int CONTR_IE  = 2;

  // ISTR bits, rest read as zero
  localparam int ISTR_INT_P   = 0;
  localparam int ISTR_RUN     = 1;
  localparam int ISTR_SCSI    = 2;
  localparam int ISTR_FLUSHED = 3;

endpackage

`default_nettype wire

//--- include/sdmac_cfg.svh
// SDMAC register interface configuration
`ifndef SDMAC_CFG_SVH
`define SDMAC_CFG_SVH

// CPU data bus width
`define SDMAC_DW 32

// Value returned by a VERSION read
`define SDMAC_VERSION 32'h0003_0001

// ACR advance per DMA transfer, one longword
`define SDMAC_ACR_STEP 4

`endif
